// ==== hw/replay_defines.svh ====
// ====================
// Replay staging parameters
// Queue count, ring geometry, word width and admission headroom
// ====================
`ifndef REPLAY_DEFINES_SVH
`define REPLAY_DEFINES_SVH

// Number of queue rings and width of a queue ID
`define REPLAY_NUM_QUEUES 4
`define REPLAY_QID_W 2

// Address bits inside one ring, 16 words each
`define REPLAY_RING_AW 4

`define REPLAY_DATA_W 32

// Free words needed to admit a packet, also the longest packet
`define REPLAY_HEADROOM 4

// Input FIFO address bits, 8 entries
`define REPLAY_FIFO_AW 3

`endif

// ==== hw/replay_pkg.sv ====
// ====================
// Replay staging types
// Tagged word, memory write request and writer FSM states
// ====================
`include "replay_defines.svh"

package replay_pkg;

  // One tagged word as carried through the input FIFO and to the output
  typedef struct packed {
    logic [`REPLAY_DATA_W-1:0] data;
    logic [`REPLAY_QID_W-1:0]  qid;
    logic                      eop;
  } replay_word_t;

  // Ring RAM write, address is {queue ID, ring index}
  typedef struct packed {
    logic [`REPLAY_QID_W+`REPLAY_RING_AW-1:0] addr;
    logic [`REPLAY_DATA_W-1:0]                data;
  } ram_wr_t;

  // Writer FSM
  typedef enum logic [1:0] {
    IDLE,
    WR_PKT,
    DROP
  } wr_state_t;

endpackage

// ==== hw/input_fifo.sv ====
// ====================
// Input FIFO
// Show-ahead register FIFO for tagged words ahead of the writer
// ====================
`timescale 1ns/1ps
`include "replay_defines.svh"

module input_fifo (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_push,
  input  replay_pkg::replay_word_t in_word,
  output logic                    in_full,
  input  logic                    fifo_pop,
  output replay_pkg::replay_word_t fifo_word,
  output logic                    fifo_empty
);
  import replay_pkg::*;

  replay_word_t mem [1 << `REPLAY_FIFO_AW];

  logic [`REPLAY_FIFO_AW-1:0] wr_ptr;
  logic [`REPLAY_FIFO_AW-1:0] rd_ptr;
  // One extra bit so a full FIFO is distinct from an empty one
  logic [`REPLAY_FIFO_AW:0]   count;
  logic                       push_ok;
  logic                       pop_ok;

  assign in_full    = count[`REPLAY_FIFO_AW];
  assign fifo_empty = (count == '0);
  assign push_ok    = in_push && !in_full;
  assign pop_ok     = fifo_pop && !fifo_empty;

  // Head entry is always visible
  assign fifo_word = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= in_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Source must hold off while full, writer must not pop an empty FIFO
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    !(in_push && in_full))
    else $error("input_fifo: push while full");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    !(fifo_pop && fifo_empty))
    else $error("input_fifo: pop while empty");

endmodule

// ==== hw/fifo_to_mem.sv ====
// ====================
// FIFO to memory writer
// Admits or drops each packet from its queue's free space,
// then writes admitted words into that queue's ring
// ====================
`timescale 1ns/1ps
`include "replay_defines.svh"

module fifo_to_mem (
  input  logic                          clk,
  input  logic                          rst,
  input  replay_pkg::replay_word_t      fifo_word,
  input  logic                          fifo_empty,
  output logic                          fifo_pop,
  input  logic                          mem_ready,
  input  logic [`REPLAY_NUM_QUEUES-1:0] space_ok,
  input  logic [`REPLAY_RING_AW-1:0]    tail_idx [`REPLAY_NUM_QUEUES],
  output logic [`REPLAY_NUM_QUEUES-1:0] tail_inc,
  output logic                          ram_wr,
  output replay_pkg::ram_wr_t           ram_wr_req,
  output logic                          drop_pulse
);
  import replay_pkg::*;

  wr_state_t                state;
  wr_state_t                state_next;
  logic [`REPLAY_QID_W-1:0] cur_q;
  logic [`REPLAY_QID_W-1:0] cur_q_next;
  // Set on entry to DROP until the first word is discarded
  logic                     drop_armed;
  logic                     wr_fire;

  always_comb begin
    state_next = state;
    cur_q_next = cur_q;
    fifo_pop   = 1'b0;
    wr_fire    = 1'b0;
    tail_inc   = '0;

    case (state)
      IDLE: begin
        // Admission is decided once, on the first word of the packet
        if (!fifo_empty) begin
          cur_q_next = fifo_word.qid;
          state_next = space_ok[fifo_word.qid] ? WR_PKT : DROP;
        end
      end

      WR_PKT: begin
        if (!fifo_empty && mem_ready) begin
          fifo_pop        = 1'b1;
          wr_fire         = 1'b1;
          tail_inc[cur_q] = 1'b1;
          if (fifo_word.eop) begin
            state_next = IDLE;
          end
        end
      end

      DROP: begin
        // Discard regardless of mem_ready
        if (!fifo_empty) begin
          fifo_pop = 1'b1;
          if (fifo_word.eop) begin
            state_next = IDLE;
          end
        end
      end

      default: state_next = IDLE;
    endcase
  end

  assign drop_pulse = fifo_pop && drop_armed;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      cur_q      <= '0;
      drop_armed <= 1'b0;
      ram_wr     <= 1'b0;
    end else begin
      state  <= state_next;
      cur_q  <= cur_q_next;
      ram_wr <= wr_fire;
      if (state == IDLE && state_next == DROP) begin
        drop_armed <= 1'b1;
      end else if (fifo_pop) begin
        drop_armed <= 1'b0;
      end
    end
  end

  // Write request, issued the cycle after the pop
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      ram_wr_req.addr <= {cur_q, tail_idx[cur_q]};
      ram_wr_req.data <= fifo_word.data;
    end
  end

  // Every word popped must belong to the packet's latched queue
  a_qid_stable: assert property (@(posedge clk) disable iff (rst)
    fifo_pop |-> (fifo_word.qid == cur_q))
    else $error("fifo_to_mem: queue ID changed within a packet");

endmodule

// ==== hw/queue_ring_ptr.sv ====
// ====================
// Queue ring pointers
// Head, tail and committed tail of one ring,
// with fill level, empty flag and admission check
// ====================
`timescale 1ns/1ps
`include "replay_defines.svh"

module queue_ring_ptr (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       tail_inc,
  input  logic                       head_inc,
  output logic [`REPLAY_RING_AW-1:0] tail_idx,
  output logic [`REPLAY_RING_AW-1:0] head_idx,
  output logic                       not_empty,
  output logic                       space_ok
);

  // Ring size as a wrap-extended value
  localparam logic [`REPLAY_RING_AW:0] DEPTH = {1'b1, {`REPLAY_RING_AW{1'b0}}};

  // Pointers carry a wrap bit above the index
  logic [`REPLAY_RING_AW:0] tail;
  logic [`REPLAY_RING_AW:0] tail_c;
  logic [`REPLAY_RING_AW:0] head;
  logic [`REPLAY_RING_AW:0] used;
  logic [`REPLAY_RING_AW:0] free;

  assign tail_idx = tail[`REPLAY_RING_AW-1:0];
  assign head_idx = head[`REPLAY_RING_AW-1:0];

  // Fill counted from the raw tail so admission sees words in flight
  assign used     = tail - head;
  assign free     = DEPTH - used;
  assign space_ok = (free >= `REPLAY_HEADROOM);

  // Reader only sees words whose RAM write has landed
  assign not_empty = (tail_c != head);

  always_ff @(posedge clk) begin
    if (rst) begin
      tail   <= '0;
      tail_c <= '0;
      head   <= '0;
    end else begin
      tail_c <= tail;
      if (tail_inc) begin
        tail <= tail + 1'b1;
      end
      if (head_inc) begin
        head <= head + 1'b1;
      end
    end
  end

  a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
    head_inc |-> not_empty)
    else $error("queue_ring_ptr: head advanced on empty ring");

  a_no_write_full: assert property (@(posedge clk) disable iff (rst)
    tail_inc |-> (used != DEPTH))
    else $error("queue_ring_ptr: tail advanced on full ring");

endmodule

// ==== hw/ring_ram.sv ====
// ====================
// Ring RAM
// One-write one-read on-chip memory shared by all rings,
// indexed by {queue ID, ring index}
// ====================
`timescale 1ns/1ps
`include "replay_defines.svh"

module ring_ram (
  input  logic                                     clk,
  input  logic                                     ram_wr,
  input  replay_pkg::ram_wr_t                      ram_wr_req,
  input  logic                                     ram_rd,
  input  logic [`REPLAY_QID_W+`REPLAY_RING_AW-1:0] ram_rd_addr,
  output logic [`REPLAY_DATA_W-1:0]                ram_rd_data
);

  logic [`REPLAY_DATA_W-1:0] mem [1 << (`REPLAY_QID_W + `REPLAY_RING_AW)];

  always_ff @(posedge clk) begin
    if (ram_wr) begin
      mem[ram_wr_req.addr] <= ram_wr_req.data;
    end
  end

  // Registered read, data one cycle after ram_rd
  always_ff @(posedge clk) begin
    if (ram_rd) begin
      ram_rd_data <= mem[ram_rd_addr];
    end
  end

endmodule

// ==== hw/ring_reader.sv ====
// ====================
// Ring reader
// Drains non-empty rings round-robin, one read per cycle,
// and tags returning data with its queue ID
// ====================
`timescale 1ns/1ps
`include "replay_defines.svh"

module ring_reader (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     out_en,
  input  logic [`REPLAY_NUM_QUEUES-1:0]            not_empty,
  input  logic [`REPLAY_RING_AW-1:0]               head_idx [`REPLAY_NUM_QUEUES],
  output logic [`REPLAY_NUM_QUEUES-1:0]            head_inc,
  output logic                                     ram_rd,
  output logic [`REPLAY_QID_W+`REPLAY_RING_AW-1:0] ram_rd_addr,
  input  logic [`REPLAY_DATA_W-1:0]                ram_rd_data,
  output logic                                     out_valid,
  output replay_pkg::replay_word_t                 out_word
);

  // Last queue served
  logic [`REPLAY_QID_W-1:0] rr_ptr;
  logic [`REPLAY_QID_W-1:0] sel;
  // Queue of the read in flight
  logic [`REPLAY_QID_W-1:0] qid_pend;
  logic                     issue;

  // First non-empty queue after rr_ptr, wrapping back to rr_ptr itself
  always_comb begin
    logic [`REPLAY_QID_W-1:0] cand;
    logic                     found;
    sel   = rr_ptr;
    found = 1'b0;
    for (int i = 1; i <= `REPLAY_NUM_QUEUES; i++) begin
      cand = rr_ptr + i[`REPLAY_QID_W-1:0];
      if (!found && not_empty[cand]) begin
        sel   = cand;
        found = 1'b1;
      end
    end
  end

  assign issue       = out_en && (|not_empty);
  assign ram_rd      = issue;
  assign ram_rd_addr = {sel, head_idx[sel]};

  always_comb begin
    head_inc = '0;
    if (issue) begin
      head_inc[sel] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr    <= '1;
      out_valid <= 1'b0;
    end else begin
      out_valid <= issue;
      if (issue) begin
        rr_ptr <= sel;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      qid_pend <= sel;
    end
  end

  // RAM output register carries the data, eop is not replayed
  assign out_word.data = ram_rd_data;
  assign out_word.qid  = qid_pend;
  assign out_word.eop  = 1'b0;

endmodule

// ==== hw/replay_stage_top.sv ====
// ====================
// Replay staging top
// Input FIFO, packet writer, per-queue ring pointers,
// ring RAM and round-robin reader
// ====================
`timescale 1ns/1ps
`include "replay_defines.svh"

module replay_stage_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_push,
  input  replay_pkg::replay_word_t in_word,
  output logic                     in_full,
  input  logic                     mem_ready,
  input  logic                     out_en,
  output logic                     out_valid,
  output replay_pkg::replay_word_t out_word,
  output logic                     drop_pulse
);
  import replay_pkg::*;

  replay_word_t fifo_word;
  logic         fifo_empty;
  logic         fifo_pop;

  logic [`REPLAY_NUM_QUEUES-1:0] space_ok;
  logic [`REPLAY_NUM_QUEUES-1:0] not_empty;
  logic [`REPLAY_NUM_QUEUES-1:0] tail_inc;
  logic [`REPLAY_NUM_QUEUES-1:0] head_inc;
  logic [`REPLAY_RING_AW-1:0]    tail_idx [`REPLAY_NUM_QUEUES];
  logic [`REPLAY_RING_AW-1:0]    head_idx [`REPLAY_NUM_QUEUES];

  ram_wr_t                                  ram_wr_req;
  logic                                     ram_wr;
  logic                                     ram_rd;
  logic [`REPLAY_QID_W+`REPLAY_RING_AW-1:0] ram_rd_addr;
  logic [`REPLAY_DATA_W-1:0]                ram_rd_data;

  input_fifo u_fifo (
    .clk        (clk),
    .rst        (rst),
    .in_push    (in_push),
    .in_word    (in_word),
    .in_full    (in_full),
    .fifo_pop   (fifo_pop),
    .fifo_word  (fifo_word),
    .fifo_empty (fifo_empty)
  );

  fifo_to_mem u_writer (
    .clk        (clk),
    .rst        (rst),
    .fifo_word  (fifo_word),
    .fifo_empty (fifo_empty),
    .fifo_pop   (fifo_pop),
    .mem_ready  (mem_ready),
    .space_ok   (space_ok),
    .tail_idx   (tail_idx),
    .tail_inc   (tail_inc),
    .ram_wr     (ram_wr),
    .ram_wr_req (ram_wr_req),
    .drop_pulse (drop_pulse)
  );

  // One ring per queue
  for (genvar q = 0; q < `REPLAY_NUM_QUEUES; q++) begin : g_ring
    queue_ring_ptr u_ring (
      .clk       (clk),
      .rst       (rst),
      .tail_inc  (tail_inc[q]),
      .head_inc  (head_inc[q]),
      .tail_idx  (tail_idx[q]),
      .head_idx  (head_idx[q]),
      .not_empty (not_empty[q]),
      .space_ok  (space_ok[q])
    );
  end

  ring_ram u_ram (
    .clk         (clk),
    .ram_wr      (ram_wr),
    .ram_wr_req  (ram_wr_req),
    .ram_rd      (ram_rd),
    .ram_rd_addr (ram_rd_addr),
    .ram_rd_data (ram_rd_data)
  );

  ring_reader u_reader (
    .clk         (clk),
    .rst         (rst),
    .out_en      (out_en),
    .not_empty   (not_empty),
    .head_idx    (head_idx),
    .head_inc    (head_inc),
    .ram_rd      (ram_rd),
    .ram_rd_addr (ram_rd_addr),
    .ram_rd_data (ram_rd_data),
    .out_valid   (out_valid),
    .out_word    (out_word)
  );

endmodule

// ==== sim/replay_stage_tb.sv ====
// ====================
// Replay staging testbench
// Random packets on all queues, drop checks on a full ring,
// memory stalls and per-queue ordering of the output
// ====================
`timescale 1ns/1ps
`include "replay_defines.svh"

module replay_stage_tb;
  import replay_pkg::*;

  localparam int TIMEOUT   = 2000;
  localparam int RING_SIZE = 1 << `REPLAY_RING_AW;
  // Ring fill at which a new packet is still admitted
  localparam int ADMIT_MAX = RING_SIZE - `REPLAY_HEADROOM;

  logic         clk;
  logic         rst;
  logic         in_push;
  replay_word_t in_word;
  logic         in_full;
  logic         mem_ready;
  logic         out_en;
  logic         out_valid;
  replay_word_t out_word;
  logic         drop_pulse;

  // Expected data per queue, consumed through rd_idx
  logic [`REPLAY_DATA_W-1:0] exp_q [`REPLAY_NUM_QUEUES][$];
  int                        rd_idx [`REPLAY_NUM_QUEUES];
  int                        drops_exp;
  int                        drops_seen;

  logic                      chk_valid;
  logic                      chk_unexp;
  logic [`REPLAY_DATA_W-1:0] chk_got;
  logic [`REPLAY_DATA_W-1:0] chk_exp;
  int                        chk_qid;
  logic                      idle_chk;
  logic                      drop_chk;
  logic                      burst_chk;
  logic                      stall_en;

  replay_stage_top dut (
    .clk        (clk),
    .rst        (rst),
    .in_push    (in_push),
    .in_word    (in_word),
    .in_full    (in_full),
    .mem_ready  (mem_ready),
    .out_en     (out_en),
    .out_valid  (out_valid),
    .out_word   (out_word),
    .drop_pulse (drop_pulse)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  function automatic int unread(input int q);
    return exp_q[q].size() - rd_idx[q];
  endfunction

  // Admission follows the ring fill when the packet is sent
  task automatic send_packet(input int q, input int len);
    replay_word_t w;
    int           t;
    bit           admit;
    admit = (unread(q) <= ADMIT_MAX);
    for (int i = 0; i < len; i++) begin
      w.data = $urandom;
      w.qid  = q[`REPLAY_QID_W-1:0];
      w.eop  = (i == len - 1);
      t = 0;
      while (in_full) begin
        if (t >= TIMEOUT) stop_run("timeout: input FIFO stayed full");
        idle_cycles(1);
        t++;
      end
      in_push = 1'b1;
      in_word = w;
      idle_cycles(1);
      in_push = 1'b0;
      if (admit) begin
        exp_q[q].push_back(w.data);
      end
    end
    if (!admit) begin
      drops_exp++;
    end
  endtask

  // Hold a packet back until its admission is certain
  task automatic wait_room(input int q);
    int t;
    t = 0;
    while (unread(q) > ADMIT_MAX) begin
      if (t >= TIMEOUT) stop_run("timeout: ring never drained below headroom");
      idle_cycles(1);
      t++;
    end
  endtask

  task automatic wait_drained();
    int t;
    int left;
    t    = 0;
    left = 1;
    while (left != 0) begin
      left = 0;
      for (int q = 0; q < `REPLAY_NUM_QUEUES; q++) begin
        left += unread(q);
      end
      if (left != 0) begin
        if (t >= TIMEOUT) stop_run("timeout: expected words never reached the output");
        idle_cycles(1);
        t++;
      end
    end
  endtask

  task automatic wait_drops();
    int t;
    t = 0;
    while (drops_seen < drops_exp) begin
      if (t >= TIMEOUT) stop_run("timeout: too few drop pulses");
      idle_cycles(1);
      t++;
    end
  endtask

  // Random stretches of mem_ready low
  initial begin
    int stall_left;
    mem_ready  = 1'b1;
    stall_left = 0;
    forever begin
      @(posedge clk);
      #1;
      if (stall_en && stall_left > 0) begin
        mem_ready = 1'b0;
        stall_left--;
      end else if (stall_en && $urandom_range(0, 3) == 0) begin
        mem_ready  = 1'b0;
        stall_left = $urandom_range(0, 5);
      end else begin
        mem_ready = 1'b1;
      end
    end
  end

  // Output monitor, samples at the falling edge where outputs are stable
  initial begin
    int qi;
    chk_valid  = 1'b0;
    chk_unexp  = 1'b0;
    chk_got    = '0;
    chk_exp    = '0;
    chk_qid    = 0;
    drops_seen = 0;
    for (int q = 0; q < `REPLAY_NUM_QUEUES; q++) begin
      rd_idx[q] = 0;
    end
    forever begin
      @(negedge clk);
      chk_valid = 1'b0;
      chk_unexp = 1'b0;
      if (!rst && out_valid) begin
        qi      = int'(out_word.qid);
        chk_qid = qi;
        if (rd_idx[qi] >= exp_q[qi].size()) begin
          chk_unexp = 1'b1;
        end else begin
          chk_valid = 1'b1;
          chk_got   = out_word.data;
          chk_exp   = exp_q[qi][rd_idx[qi]];
          rd_idx[qi]++;
        end
      end
      if (!rst && drop_pulse) begin
        drops_seen++;
      end
    end
  end

  a_out_data: assert property (@(posedge clk) disable iff (rst)
    chk_valid |-> (chk_got == chk_exp))
    else stop_run($sformatf("mismatch at %0t: out_word.data (queue %0d) got %h expected %h",
                            $time, chk_qid, chk_got, chk_exp));

  a_out_known: assert property (@(posedge clk) disable iff (rst) !chk_unexp)
    else stop_run($sformatf("output word on queue %0d with no expected word left", chk_qid));

  a_out_eop: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> !out_word.eop)
    else stop_run($sformatf("mismatch at %0t: out_word.eop got 1 expected 0", $time));

  a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
    idle_chk |-> (!out_valid && !drop_pulse))
    else stop_run("output or drop activity while no input was sent");

  // Stored words leave back to back once the output opens
  a_no_stall: assert property (@(posedge clk) disable iff (rst)
    burst_chk |-> out_valid)
    else stop_run("output stalled while a queue held data");

  a_drop_count: assert property (@(posedge clk) disable iff (rst)
    drop_chk |-> (drops_seen == drops_exp))
    else stop_run($sformatf("mismatch at %0t: drop_pulse count got %0d expected %0d",
                            $time, drops_seen, drops_exp));

  initial begin
    int q;
    int n_held;
    void'($urandom(32'h6e8ea90a));
    rst       = 1'b1;
    in_push   = 1'b0;
    in_word   = '0;
    out_en    = 1'b0;
    idle_chk  = 1'b0;
    drop_chk  = 1'b0;
    burst_chk = 1'b0;
    stall_en  = 1'b0;
    drops_exp = 0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    // Quiet after reset
    out_en   = 1'b1;
    idle_chk = 1'b1;
    idle_cycles(20);
    idle_chk = 1'b0;

    // One packet per queue
    for (int i = 0; i < `REPLAY_NUM_QUEUES; i++) begin
      send_packet(i, $urandom_range(1, `REPLAY_HEADROOM));
    end
    wait_drained();
    idle_cycles(3);

    // Output off, one full packet parked on every other queue
    out_en = 1'b0;
    for (int i = 0; i < `REPLAY_NUM_QUEUES; i++) begin
      if (i != 1) begin
        send_packet(i, `REPLAY_HEADROOM);
      end
    end
    // Fill queue 1 so that its last two packets drop
    for (int i = 0; i < 4; i++) begin
      send_packet(1, `REPLAY_HEADROOM);
    end
    for (int i = 0; i < 2; i++) begin
      send_packet(1, $urandom_range(1, `REPLAY_HEADROOM));
    end
    wait_drops();
    idle_cycles(10);
    drop_chk = 1'b1;
    idle_cycles(1);
    drop_chk = 1'b0;

    // Every parked word comes out on consecutive cycles
    n_held = 0;
    for (int i = 0; i < `REPLAY_NUM_QUEUES; i++) begin
      n_held += unread(i);
    end
    out_en = 1'b1;
    idle_cycles(1);
    burst_chk = 1'b1;
    idle_cycles(n_held);
    burst_chk = 1'b0;
    wait_drained();
    idle_cycles(3);

    // Random traffic under memory stalls
    stall_en = 1'b1;
    for (int i = 0; i < 40; i++) begin
      q = $urandom_range(0, `REPLAY_NUM_QUEUES - 1);
      wait_room(q);
      send_packet(q, $urandom_range(1, `REPLAY_HEADROOM));
    end
    wait_drained();
    stall_en = 1'b0;
    idle_cycles(3);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+hw
hw/replay_pkg.sv
hw/input_fifo.sv
hw/fifo_to_mem.sv
hw/queue_ring_ptr.sv
hw/ring_ram.sv
hw/ring_reader.sv
hw/replay_stage_top.sv
sim/replay_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the replay staging testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module replay_stage_tb \
  -Mdir obj_dir -o replay_stage_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/replay_stage_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi
